/* verilog/mrd_pkg.sv */
package mrd_pkg;

	// --------------------
	// sizes
	// --------------------

	// butterfly points, radix 5 at most
	localparam int n_lanes = 5;
	// banks, one per residue mod 7
	localparam int n_banks = 7;
	// linear sample address
	localparam int w_addr = 12;
	// address inside one bank
	localparam int w_bank_addr = 9;
	// one real or imag part
	localparam int w_data = 16;

	// bank index of an unused lane
	localparam logic [2:0] bank_none = 3'd7;

	// --------------------
	// types
	// --------------------

	typedef enum logic [1:0]
	{
		st_idle,
		st_read,
		st_drain
	} mrd_state_e;

	typedef struct packed
	{
		logic signed [w_data-1:0] re;
		logic signed [w_data-1:0] im;
	} cplx_t;

	// linear addresses of one butterfly, lane 0 in the low slot
	typedef struct packed
	{
		logic [n_lanes-1:0][w_addr-1:0] addr;
		logic [n_lanes-1:0] valid;
		logic [2:0] radix;
	} lane_addr_t;

	// one read request per bank
	typedef struct packed
	{
		logic [n_banks-1:0] en;
		logic [n_banks-1:0][w_bank_addr-1:0] addr;
	} bank_rd_t;

	// gathered butterfly
	typedef struct packed
	{
		logic valid;
		logic [2:0] radix;
		cplx_t [n_lanes-1:0] data;
	} rd_out_t;

endpackage

/* verilog/mrd_pass_fsm.sv */
`timescale 1ns/10ps

module mrd_pass_fsm
	import mrd_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	input  logic       rd_end,
	input  logic       last_issue,
	output mrd_state_e state,
	output logic       busy
);

	mrd_state_e state_next;

	// --------------------
	// next state
	// --------------------
	always_comb
	begin
		state_next = state;
		case (state)
			st_idle:
			begin
				// start only counts here
				if (start)
					state_next = st_read;
			end
			st_read:
			begin
				// final butterfly issued
				if (last_issue)
					state_next = st_drain;
			end
			st_drain:
			begin
				// wait for the last lane data to leave
				if (rd_end)
					state_next = st_idle;
			end
			default:
				state_next = st_idle;
		endcase
	end

	// --------------------
	// state and busy
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			busy <= 1'b0;
		end
		else
		begin
			state <= state_next;
			// follows the state, so high across read and drain
			busy <= (state_next != st_idle);
		end
	end

endmodule

/* verilog/mrd_rd_counter.sv */
`timescale 1ns/10ps

module mrd_rd_counter
	import mrd_pkg::*;
#(
	parameter int wait_cycles = 3
)
(
	input  logic       clk,
	input  logic       rst_n,
	input  mrd_state_e state,
	input  logic [7:0] n_bfly,
	output logic       issue,
	output logic [7:0] bfly_idx,
	output logic       last_issue
);

	localparam int w_wait = $clog2(wait_cycles + 1);

	logic [w_wait-1:0] wait_cnt;
	logic [7:0] last_idx;

	// index of the final butterfly of the pass
	assign last_idx = n_bfly - 8'd1;
	assign last_issue = issue && (bfly_idx == last_idx);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wait_cnt <= '0;
			issue <= 1'b0;
			bfly_idx <= '0;
		end
		else if (state == st_idle)
		begin
			// timer armed, ready for entry into st_read
			wait_cnt <= w_wait'(wait_cycles);
			issue <= 1'b0;
			bfly_idx <= '0;
		end
		else
		begin
			// start-up wait, runs down once per pass
			if (wait_cnt != '0)
				wait_cnt <= wait_cnt - 1'b1;

			// timer expiry opens the issue window
			if (wait_cnt == w_wait'(1))
			begin
				issue <= 1'b1;
				bfly_idx <= '0;
			end
			else if (issue)
			begin
				// one butterfly per cycle, no stall
				if (last_issue)
					issue <= 1'b0;
				else
					bfly_idx <= bfly_idx + 8'd1;
			end
		end
	end

endmodule

/* verilog/mrd_bfly_addr.sv */
`timescale 1ns/10ps

module mrd_bfly_addr
	import mrd_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              issue,
	input  logic [7:0]        bfly_idx,
	input  logic [2:0]        radix,
	input  logic [w_addr-1:0] stride,
	output lane_addr_t        lanes
);

	// running sum, lane j sits j strides above the butterfly
	logic [n_lanes-1:0][w_addr-1:0] acc;
	logic [n_lanes-1:0] lane_vld;

	// --------------------
	// lane addresses
	// --------------------
	always_comb
	begin
		acc[0] = w_addr'(bfly_idx);
		// chained adders instead of j * stride
		for (int j = 1; j < n_lanes; j++)
			acc[j] = acc[j-1] + stride;
	end

	// lanes below the radix, only while a butterfly is issued
	always_comb
	begin
		for (int j = 0; j < n_lanes; j++)
			lane_vld[j] = issue && (3'(j) < radix);
	end

	// --------------------
	// address register
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			lanes <= '0;
		else
		begin
			lanes.addr <= acc;
			lanes.valid <= lane_vld;
			lanes.radix <= radix;
		end
	end

endmodule

/* verilog/mrd_bank_map.sv */
`timescale 1ns/10ps

module mrd_bank_map
	import mrd_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  lane_addr_t          lanes,
	output bank_rd_t            rd_req,
	input  cplx_t [n_banks-1:0] bank_dout,
	output rd_out_t             out,
	output logic                rd_end
);

	// per lane quotient and remainder by 7
	logic [n_lanes-1:0][w_bank_addr-1:0] quo_c;
	logic [n_lanes-1:0][2:0] idx_c;
	bank_rd_t req_c;

	// delay line towards the RAM output
	logic [1:0][n_lanes-1:0][2:0] idx_d;
	logic [1:0][2:0] radix_d;
	logic [1:0] vld_d;

	// --------------------
	// divide by 7
	// --------------------
	always_comb
	begin
		for (int j = 0; j < n_lanes; j++)
		begin
			quo_c[j] = w_bank_addr'(lanes.addr[j] / 7);
			// unused lane gets no bank
			idx_c[j] = lanes.valid[j] ? 3'(lanes.addr[j] % 7) : bank_none;
		end
	end

	// lanes land in distinct banks, no conflict check
	always_comb
	begin
		req_c = '0;
		for (int j = 0; j < n_lanes; j++)
		begin
			if (idx_c[j] != bank_none)
			begin
				req_c.en[idx_c[j]] = 1'b1;
				req_c.addr[idx_c[j]] = quo_c[j];
			end
		end
	end

	// --------------------
	// bank map register
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_req <= '0;
			vld_d <= '0;
		end
		else
		begin
			rd_req <= req_c;
			// lane 0 is always used, any valid bit marks a butterfly
			vld_d <= {vld_d[0], |lanes.valid};
		end
	end

	// indices and radix ride along, two stages to meet the RAM data
	always_ff @(posedge clk)
	begin
		idx_d <= {idx_d[0], idx_c};
		radix_d <= {radix_d[0], lanes.radix};
	end

	// --------------------
	// output select
	// --------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			out <= '0;
			rd_end <= 1'b0;
		end
		else
		begin
			out.valid <= vld_d[1];
			out.radix <= radix_d[1];
			for (int j = 0; j < n_lanes; j++)
			begin
				if (idx_d[1][j] == bank_none)
					out.data[j] <= '0;
				else
					out.data[j] <= bank_dout[idx_d[1][j]];
			end
			// falling edge of the delayed valid, same cycle as the last output
			rd_end <= vld_d[1] && !vld_d[0];
		end
	end

endmodule

/* verilog/mrd_bank_ram.sv */
`timescale 1ns/10ps

module mrd_bank_ram
	import mrd_pkg::*;
#(
	parameter int bank_depth = 512
)
(
	input  logic                clk,
	input  logic                wr_en,
	input  logic [w_addr-1:0]   wr_addr,
	input  cplx_t               wr_data,
	input  bank_rd_t            rd_req,
	output cplx_t [n_banks-1:0] bank_dout
);

	// seven sample arrays
	cplx_t mem [n_banks][bank_depth];

	logic [2:0] wr_bank;
	logic [w_bank_addr-1:0] wr_baddr;

	// --------------------
	// write decode
	// --------------------
	// bank from the residue, row from the quotient
	assign wr_bank = 3'(wr_addr % 7);
	assign wr_baddr = w_bank_addr'(wr_addr / 7);

	always_ff @(posedge clk)
	begin
		for (int b = 0; b < n_banks; b++)
		begin
			if (wr_en && (wr_bank == 3'(b)))
				mem[b][wr_baddr] <= wr_data;
			// registered read, holds when not enabled
			if (rd_req.en[b])
				bank_dout[b] <= mem[b][rd_req.addr[b]];
		end
	end

endmodule

/* verilog/mrd_rd_top.sv */
`timescale 1ns/10ps

module mrd_rd_top
	import mrd_pkg::*;
#(
	parameter int wait_cycles = 3,
	parameter int bank_depth = 512
)
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  logic [2:0]        radix,
	input  logic [7:0]        n_bfly,
	input  logic [w_addr-1:0] stride,
	input  logic              wr_en,
	input  logic [w_addr-1:0] wr_addr,
	input  cplx_t             wr_data,
	output logic              busy,
	output rd_out_t           out,
	output logic              rd_end
);

	mrd_state_e state;
	logic issue;
	logic last_issue;
	logic [7:0] bfly_idx;
	lane_addr_t lanes;
	bank_rd_t rd_req;
	cplx_t [n_banks-1:0] bank_dout;

	// pass settings, held from start to the end of the pass
	logic [2:0] radix_q;
	logic [7:0] n_bfly_q;
	logic [w_addr-1:0] stride_q;

	// --------------------
	// settings capture
	// --------------------
	always_ff @(posedge clk)
	begin
		// a start while busy leaves them alone
		if (start && (state == st_idle))
		begin
			radix_q <= radix;
			n_bfly_q <= n_bfly;
			stride_q <= stride;
		end
	end

	// --------------------
	// control path
	// --------------------
	mrd_pass_fsm u_fsm (.clk(clk), .rst_n(rst_n), .start(start), .rd_end(rd_end),
		.last_issue(last_issue), .state(state), .busy(busy));

	mrd_rd_counter #(.wait_cycles(wait_cycles)) u_cnt (.clk(clk), .rst_n(rst_n),
		.state(state), .n_bfly(n_bfly_q), .issue(issue), .bfly_idx(bfly_idx),
		.last_issue(last_issue));

	// --------------------
	// address and data path
	// --------------------
	mrd_bfly_addr u_addr (.clk(clk), .rst_n(rst_n), .issue(issue), .bfly_idx(bfly_idx),
		.radix(radix_q), .stride(stride_q), .lanes(lanes));

	mrd_bank_map u_map (.clk(clk), .rst_n(rst_n), .lanes(lanes), .rd_req(rd_req),
		.bank_dout(bank_dout), .out(out), .rd_end(rd_end));

	mrd_bank_ram #(.bank_depth(bank_depth)) u_ram (.clk(clk), .wr_en(wr_en),
		.wr_addr(wr_addr), .wr_data(wr_data), .rd_req(rd_req), .bank_dout(bank_dout));

endmodule

/* bench/mrd_rd_chk.sv */
`timescale 1ns/10ps

module mrd_rd_chk
(
	input logic clk,
	input logic rst_n,
	input logic busy,
	input logic out_valid,
	input logic rd_end
);

	// --------------------
	// handshake rules
	// --------------------

	// end marker rides on the last butterfly
	a_end_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
		rd_end |-> out_valid)
		else $error("rd_end high without out.valid");

	// no output outside a pass
	a_valid_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> busy)
		else $error("out.valid high while not busy");

	// busy only drops right after the end marker
	a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(busy) |-> $past(rd_end))
		else $error("busy fell without rd_end in the cycle before");

endmodule

/* bench/tb_mrd_rd.sv */
`timescale 1ns/10ps

module tb_mrd_rd
	import mrd_pkg::*;
();

	localparam int wait_cycles = 3;
	// four stages plus the wait plus the start sample
	localparam int exp_latency = 5 + wait_cycles;
	localparam int model_depth = 1024;
	// cycles allowed before a wait gives up
	localparam int wait_limit = 50;

	logic clk;
	logic rst_n;
	logic start;
	logic [2:0] radix;
	logic [7:0] n_bfly;
	logic [w_addr-1:0] stride;
	logic wr_en;
	logic [w_addr-1:0] wr_addr;
	cplx_t wr_data;
	logic busy;
	rd_out_t dut_out;
	logic rd_end;

	// mirror of every sample written
	cplx_t model [model_depth];
	int err_cnt;
	int chk_cnt;
	// set once a wait runs out
	bit timed_out;

	mrd_rd_top #(.wait_cycles(wait_cycles), .bank_depth(512)) uut (.clk(clk), .rst_n(rst_n),
		.start(start), .radix(radix), .n_bfly(n_bfly), .stride(stride), .wr_en(wr_en),
		.wr_addr(wr_addr), .wr_data(wr_data), .busy(busy), .out(dut_out), .rd_end(rd_end));

	bind mrd_rd_top mrd_rd_chk u_chk (.clk(clk), .rst_n(rst_n), .busy(busy),
		.out_valid(out.valid), .rd_end(rd_end));

	// 100 ns period
	always #50 clk = ~clk;

	// --------------------
	// helpers
	// --------------------
	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		chk_cnt++;
		if (expected !== actual)
		begin
			err_cnt++;
			$display("FAIL %s expected %0h got %0h", name, expected, actual);
		end
	endtask

	// closing report and end of run
	task automatic finish_run();
		$display("checks: %0d errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	endtask

	// one sample per cycle while the outputs stay quiet
	task automatic write_sample(input int a, input cplx_t d);
		@(posedge clk);
		wr_en <= 1'b1;
		wr_addr <= w_addr'(a);
		wr_data <= d;
		model[a] = d;
		@(negedge clk);
		check_value("busy", 0, busy);
		check_value("out.valid", 0, dut_out.valid);
		check_value("rd_end", 0, rd_end);
	endtask

	task automatic rewrite_some(input int count);
		for (int i = 0; i < count; i++)
			write_sample($urandom_range(0, model_depth - 1), cplx_t'($urandom));
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	// --------------------
	// one read pass
	// --------------------
	task automatic run_pass(input logic [2:0] r, input logic [7:0] n,
		input logic [w_addr-1:0] s, input bit poke);
		int lat;
		int k;
		int idx;
		cplx_t exp_d;
		@(posedge clk);
		start <= 1'b1;
		radix <= r;
		n_bfly <= n;
		stride <= s;
		lat = 0;
		do
		begin
			@(posedge clk);
			lat++;
			if (lat == 1)
			begin
				// junk on the inputs once the settings are held
				start <= 1'b0;
				radix <= 3'($urandom_range(2, 5));
				n_bfly <= 8'($urandom);
				stride <= w_addr'($urandom);
			end
			// stray start while busy
			if (poke && lat == 3)
				start <= 1'b1;
			if (poke && lat == 4)
				start <= 1'b0;
			@(negedge clk);
			check_value("busy", 1, busy);
			if (!dut_out.valid)
				check_value("rd_end", 0, rd_end);
			if (lat > wait_limit)
			begin
				$display("timeout: no valid output within %0d cycles of start", lat);
				err_cnt++;
				timed_out = 1'b1;
				return;
			end
		end
		while (!dut_out.valid);
		check_value("latency", exp_latency, lat);

		// back to back butterflies
		k = 0;
		while (dut_out.valid)
		begin
			check_value("out.radix", r, dut_out.radix);
			check_value("busy", 1, busy);
			check_value("rd_end", (k == int'(n) - 1), rd_end);
			for (int j = 0; j < n_lanes; j++)
			begin
				idx = k + j * int'(s);
				if (j < int'(r))
					exp_d = model[idx];
				else
					exp_d = '0;
				check_value($sformatf("out.data[%0d] bfly %0d", j, k), exp_d, dut_out.data[j]);
			end
			k++;
			if (k > 256)
			begin
				$display("timeout: valid output did not end after %0d butterflies", k);
				err_cnt++;
				timed_out = 1'b1;
				return;
			end
			@(negedge clk);
		end
		check_value("valid count", n, k);
		// one cycle after rd_end
		check_value("rd_end after pass", 0, rd_end);
		check_value("busy after pass", 0, busy);
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial
	begin
		int seed;
		logic [2:0] r;
		logic [7:0] n;
		logic [w_addr-1:0] s;
		seed = 32'hc995;
		void'($urandom(seed));
		err_cnt = 0;
		chk_cnt = 0;
		timed_out = 1'b0;
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		radix = '0;
		n_bfly = '0;
		stride = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("busy after reset", 0, busy);
		check_value("out.valid after reset", 0, dut_out.valid);
		check_value("rd_end after reset", 0, rd_end);

		// random contents over the whole model area
		for (int a = 0; a < model_depth; a++)
			write_sample(a, cplx_t'($urandom));
		@(posedge clk);
		wr_en <= 1'b0;

		// shortest and longest pass back to back
		run_pass(3'd2, 8'd1, 12'd3, 1'b0);
		if (!timed_out)
			run_pass(3'd5, 8'd255, 12'd190, 1'b0);

		for (int p = 0; p < 10 && !timed_out; p++)
		begin
			rewrite_some(40);
			r = 3'($urandom_range(2, 5));
			n = 8'($urandom_range(1, 64));
			s = w_addr'($urandom_range(1, 200));
			// keep lanes in distinct banks
			if (s % 7 == 0)
				s = s + 1'b1;
			run_pass(r, n, s, p[0]);
		end
		finish_run();
	end

endmodule

/* flist.f */
verilog/mrd_pkg.sv
verilog/mrd_pass_fsm.sv
verilog/mrd_rd_counter.sv
verilog/mrd_bfly_addr.sv
verilog/mrd_bank_map.sv
verilog/mrd_bank_ram.sv
verilog/mrd_rd_top.sv
bench/mrd_rd_chk.sv
bench/tb_mrd_rd.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search the log for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module tb_mrd_rd -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
